// File: hw/soc_params.svh
//----------------------------------------------------------------------
// SOC memory map and sizing
//----------------------------------------------------------------------
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define SOC_AW 32
`define SOC_DW 32

// address window selects, compared against the top address bits
// dmem lives at 0x1000_0000 .. 0x1FFF_FFFF
`define SOC_DMEM_BASE_NIB 4'd1
// csr block lives at 0x2000_0000 .. 0x3FFF_FFFF
`define SOC_CSR_BASE_TRI 3'd1

// dmem is 4 kB of words, aliased across its whole window
`define SOC_DMEM_WORDS 1024
`define SOC_DMEM_IW 10

// read-only identification word in the csr block
`define SOC_ID_VALUE 32'h50C0_0001

// read data for accesses that hit no window
`define SOC_BUS_ERR_DATA 32'hDEAD_BEEF

`endif

// File: hw/soc_pkg.sv
//----------------------------------------------------------------------
// SOC bus types
//----------------------------------------------------------------------
`include "soc_params.svh"

package soc_pkg;

   //-------------------------------------------------------------------
   // bus request and response
   //-------------------------------------------------------------------

   // request from master, replicated by the fabric per peripheral
   // vld is held with we/addr/wdat until rdy comes back
   typedef struct packed {
      logic              vld;
      logic              we;
      logic [`SOC_AW-1:0] addr;
      logic [`SOC_DW-1:0] wdat;
   } soc_req_t;

   // response toward the master
   // rdy completes the transfer, rdat only valid for reads
   typedef struct packed {
      logic              rdy;
      logic [`SOC_DW-1:0] rdat;
   } soc_rsp_t;

   //-------------------------------------------------------------------
   // csr register map
   //-------------------------------------------------------------------

   // picked by addr[3:2], the rest of the window aliases
   typedef enum logic [1:0] {
      CSR_ID      = 2'd0,
      CSR_SCRATCH = 2'd1,
      CSR_CTRL    = 2'd2,
      CSR_ERRCNT  = 2'd3
   } csr_reg_e;

   //-------------------------------------------------------------------
   // dmem read sequencing
   //-------------------------------------------------------------------

   // idle accepts requests, rdata presents the registered word
   typedef enum logic {
      DMEM_IDLE  = 1'b0,
      DMEM_RDATA = 1'b1
   } dmem_state_e;

endpackage : soc_pkg

// File: hw/soc_fabric.sv
//----------------------------------------------------------------------
// SOC interconnect fabric
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_fabric (
   // from the cpu master
   input  soc_pkg::soc_req_t cpu_req,
   output soc_pkg::soc_rsp_t cpu_rsp,

   // to the data memory
   output soc_pkg::soc_req_t dmem_req,
   input  soc_pkg::soc_rsp_t dmem_rsp,

   // to the register block
   output soc_pkg::soc_req_t csr_req,
   input  soc_pkg::soc_rsp_t csr_rsp,

   // unmapped access completed this cycle
   output logic              decode_err
);
   import soc_pkg::*;

   //-------------------------------------------------------------------
   // address decode
   //-------------------------------------------------------------------
   logic dmem_sel;
   logic csr_sel;
   logic none_sel;

   // windows must never overlap
   // 0x1xxx_xxxx
   assign dmem_sel = (cpu_req.addr[31:28] == `SOC_DMEM_BASE_NIB);
   // 0x2xxx_xxxx and 0x3xxx_xxxx
   assign csr_sel  = (cpu_req.addr[31:29] == `SOC_CSR_BASE_TRI);
   assign none_sel = ~dmem_sel & ~csr_sel;

   //-------------------------------------------------------------------
   // request replication
   //-------------------------------------------------------------------
   // shared fields go to every peripheral as they are
   always_comb begin
      dmem_req      = cpu_req;
      csr_req       = cpu_req;
      // only the selected peripheral sees a valid
      dmem_req.vld  = cpu_req.vld & dmem_sel;
      csr_req.vld   = cpu_req.vld & csr_sel;
   end

   //-------------------------------------------------------------------
   // response mux and default responder
   //-------------------------------------------------------------------
   always_comb begin
      if (dmem_sel) begin
         cpu_rsp = dmem_rsp;
      end else if (csr_sel) begin
         cpu_rsp = csr_rsp;
      end else begin
         // nothing there, finish at once so the master does not hang
         cpu_rsp.rdy  = cpu_req.vld;
         cpu_rsp.rdat = `SOC_BUS_ERR_DATA;
      end
   end

   // one pulse per unmapped transfer, counted in the csr block
   // single cycle since the default responder is always ready
   assign decode_err = cpu_req.vld & none_sel;

endmodule : soc_fabric

// File: hw/soc_dmem.sv
//----------------------------------------------------------------------
// Data memory with write protect
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_dmem (
   input  logic              clk,
   input  logic              rst,
   // request already qualified by the fabric select
   input  soc_pkg::soc_req_t req,
   // writes are dropped while set
   input  logic              wprot,
   output soc_pkg::soc_rsp_t rsp
);
   import soc_pkg::*;

   //-------------------------------------------------------------------
   // storage
   //-------------------------------------------------------------------
   logic [`SOC_DW-1:0]     mem [`SOC_DMEM_WORDS];
   logic [`SOC_DW-1:0]     rdat_q;
   logic [`SOC_DMEM_IW-1:0] idx;
   dmem_state_e            state_q;
   logic                   wr_acc;
   logic                   rd_acc;

   // word index above the byte offset, upper bits alias
   assign idx    = req.addr[`SOC_DMEM_IW+1:2];

   // a read is only started from idle
   assign wr_acc = req.vld & req.we;
   assign rd_acc = req.vld & ~req.we & (state_q == DMEM_IDLE);

   // write port, no handshake delay
   always_ff @(posedge clk) begin
      if (wr_acc && !wprot) begin
         mem[idx] <= req.wdat;
      end
   end

   // read port, word captured for the wait state
   always_ff @(posedge clk) begin
      if (rd_acc) begin
         rdat_q <= mem[idx];
      end
   end

   //-------------------------------------------------------------------
   // read wait state FSM
   //-------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= DMEM_IDLE;
      end else begin
         case (state_q)
            DMEM_IDLE: begin
               if (rd_acc) begin
                  state_q <= DMEM_RDATA;
               end
            end
            // master holds the read, it completes here
            DMEM_RDATA: state_q <= DMEM_IDLE;
            default:    state_q <= DMEM_IDLE;
         endcase
      end
   end

   // writes finish in their first cycle even when protected
   assign rsp.rdy  = wr_acc | (state_q == DMEM_RDATA);
   assign rsp.rdat = rdat_q;

endmodule : soc_dmem

// File: hw/soc_csr.sv
//----------------------------------------------------------------------
// Control and status registers
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module soc_csr (
   input  logic              clk,
   input  logic              rst,
   // request already qualified by the fabric select
   input  soc_pkg::soc_req_t req,
   // unmapped access pulse from the fabric
   input  logic              decode_err,
   output soc_pkg::soc_rsp_t rsp,
   // write protect for the data memory
   output logic              dmem_wprot
);
   import soc_pkg::*;

   //-------------------------------------------------------------------
   // register decode
   //-------------------------------------------------------------------
   csr_reg_e           reg_sel;
   logic               wr_acc;
   logic [`SOC_DW-1:0] scratch_q;
   logic               ctrl_q;
   logic [`SOC_DW-1:0] errcnt_q;

   // four registers repeat through the whole window
   assign reg_sel = csr_reg_e'(req.addr[3:2]);
   assign wr_acc  = req.vld & req.we;

   //-------------------------------------------------------------------
   // register state
   //-------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         scratch_q <= '0;
         ctrl_q    <= 1'b0;
      end else if (wr_acc) begin
         case (reg_sel)
            CSR_SCRATCH: scratch_q <= req.wdat;
            // only the protect bit is implemented
            CSR_CTRL:    ctrl_q    <= req.wdat[0];
            // id is read-only, errcnt handled below
            default: ;
         endcase
      end
   end

   // error counter
   // a write of any value clears it
   // decode_err and a csr write cannot coincide, windows differ
   always_ff @(posedge clk) begin
      if (rst) begin
         errcnt_q <= '0;
      end else if (wr_acc && (reg_sel == CSR_ERRCNT)) begin
         errcnt_q <= '0;
      end else if (decode_err) begin
         errcnt_q <= errcnt_q + 1'b1;
      end
   end

   //-------------------------------------------------------------------
   // read mux and handshake
   //-------------------------------------------------------------------
   always_comb begin
      case (reg_sel)
         CSR_ID:      rsp.rdat = `SOC_ID_VALUE;
         CSR_SCRATCH: rsp.rdat = scratch_q;
         // upper bits read as zero
         CSR_CTRL:    rsp.rdat = {{(`SOC_DW-1){1'b0}}, ctrl_q};
         CSR_ERRCNT:  rsp.rdat = errcnt_q;
         default:     rsp.rdat = '0;
      endcase
   end

   // every access finishes in its first cycle
   assign rsp.rdy    = req.vld;

   assign dmem_wprot = ctrl_q;

endmodule : soc_csr

// File: hw/soc_top.sv
//----------------------------------------------------------------------
// SOC bus subsystem top
//----------------------------------------------------------------------
`timescale 1ns/1ps

module soc_top (
   input  logic              clk,
   input  logic              rst,
   // single cpu master port
   input  soc_pkg::soc_req_t cpu_req,
   output soc_pkg::soc_rsp_t cpu_rsp
);
   import soc_pkg::*;

   // per peripheral request and response
   soc_req_t dmem_req;
   soc_rsp_t dmem_rsp;
   soc_req_t csr_req;
   soc_rsp_t csr_rsp;

   // side band between blocks
   logic     decode_err;
   logic     dmem_wprot;

   soc_fabric u_fabric (
      .cpu_req    (cpu_req),
      .cpu_rsp    (cpu_rsp),
      .dmem_req   (dmem_req),
      .dmem_rsp   (dmem_rsp),
      .csr_req    (csr_req),
      .csr_rsp    (csr_rsp),
      .decode_err (decode_err)
   );

   soc_dmem u_dmem (
      .clk   (clk),
      .rst   (rst),
      .req   (dmem_req),
      .wprot (dmem_wprot),
      .rsp   (dmem_rsp)
   );

   // counts unmapped accesses and steers dmem write protect
   soc_csr u_csr (
      .clk        (clk),
      .rst        (rst),
      .req        (csr_req),
      .decode_err (decode_err),
      .rsp        (csr_rsp),
      .dmem_wprot (dmem_wprot)
   );

endmodule : soc_top

// File: bench/soc_properties.sv
//----------------------------------------------------------------------
// SOC bus handshake properties
//----------------------------------------------------------------------
`timescale 1ns/1ps

module soc_properties (
   input logic              clk,
   input logic              rst,
   input soc_pkg::soc_req_t cpu_req,
   input soc_pkg::soc_rsp_t cpu_rsp,
   input soc_pkg::soc_req_t dmem_req,
   input soc_pkg::soc_req_t csr_req
);
   // read by the testbench at the end of the run
   int fail_cnt = 0;

   //-------------------------------------------------------------------
   // handshake
   //-------------------------------------------------------------------
   // a response only completes a live request
   rdy_needs_vld: assert property (@(posedge clk) disable iff (rst)
      cpu_rsp.rdy |-> cpu_req.vld)
      else begin
         fail_cnt++;
         $error("cpu_rsp.rdy high while cpu_req.vld low");
      end

   // selects are exclusive so at most one peripheral sees vld
   one_target: assert property (@(posedge clk) disable iff (rst)
      !(dmem_req.vld && csr_req.vld))
      else begin
         fail_cnt++;
         $error("dmem and csr valids high together");
      end

   // stalled request is held unchanged
   req_held: assert property (@(posedge clk) disable iff (rst)
      (cpu_req.vld && !cpu_rsp.rdy) |=>
         (cpu_req.vld && $stable(cpu_req.addr) && $stable(cpu_req.we)
          && $stable(cpu_req.wdat)))
      else begin
         fail_cnt++;
         $error("request changed while waiting for rdy");
      end

endmodule : soc_properties

bind soc_top soc_properties u_props (
   .clk      (clk),
   .rst      (rst),
   .cpu_req  (cpu_req),
   .cpu_rsp  (cpu_rsp),
   .dmem_req (dmem_req),
   .csr_req  (csr_req)
);

// File: bench/tb_soc_top.sv
//----------------------------------------------------------------------
// SOC bus subsystem testbench
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc_top;
   import soc_pkg::*;

   localparam int N_TBL       = 21;
   localparam int N_RAND      = 32;
   // three cycles per transfer, reset and a margin
   localparam int TIMEOUT_CYC = 3 * (N_TBL + 2 * N_RAND) + 8 + 50;

   // one directed bus step, exp only compared when chk is set
   typedef struct packed {
      logic        we;
      logic        chk;
      logic [31:0] addr;
      logic [31:0] wdat;
      logic [31:0] exp;
   } step_t;

   logic        clk;
   logic        rst;
   soc_req_t    cpu_req;
   soc_rsp_t    cpu_rsp;
   step_t       tbl [N_TBL];
   logic [31:0] model [`SOC_DMEM_WORDS];
   logic [31:0] rnd_state;
   int          n_checks;
   int          n_errors;
   int          cycles;

   soc_top DUT (
      .clk     (clk),
      .rst     (rst),
      .cpu_req (cpu_req),
      .cpu_rsp (cpu_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // run limit
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYC) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("=== FAIL ===");
      $finish;
   end

   //-------------------------------------------------------------------
   // helpers
   //-------------------------------------------------------------------
   // xorshift32
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rnd_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rnd_state = x;
      return x;
   endfunction

   task automatic set_entry(input int i, input logic we, input logic chk,
                            input logic [31:0] addr, input logic [31:0] wdat,
                            input logic [31:0] exp);
      tbl[i] = '{we: we, chk: chk, addr: addr, wdat: wdat, exp: exp};
   endtask

   // drive on the falling edge, hold until rdy, sample before the rising edge
   task automatic bus_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      @(negedge clk);
      cpu_req.vld  = 1'b1;
      cpu_req.we   = we;
      cpu_req.addr = addr;
      cpu_req.wdat = wdat;
      #1;
      while (!cpu_rsp.rdy) begin
         @(negedge clk);
         #1;
      end
      rdat = cpu_rsp.rdat;
      // transfer completes on this edge
      @(posedge clk);
   endtask

   task automatic check_rdat(input logic [31:0] addr, input logic [31:0] exp,
                             input logic [31:0] got);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("** Error at %0d ns: cpu_rsp.rdat (addr %08h) expected %08h got %08h",
                  $time, addr, exp, got);
      end
   endtask

   //-------------------------------------------------------------------
   // directed table
   //-------------------------------------------------------------------
   task automatic load_table();
      // dmem write, read back, 4 kB alias
      set_entry(0, 1'b1, 1'b0, 32'h1000_0010, 32'h1234_5678, 32'h0);
      set_entry(1, 1'b0, 1'b1, 32'h1000_0010, 32'h0, 32'h1234_5678);
      set_entry(2, 1'b0, 1'b1, 32'h1000_1010, 32'h0, 32'h1234_5678);
      // id, scratch, 0x3xxx alias
      set_entry(3, 1'b0, 1'b1, 32'h2000_0000, 32'h0, `SOC_ID_VALUE);
      set_entry(4, 1'b1, 1'b0, 32'h2000_0004, 32'hA5A5_5A5A, 32'h0);
      set_entry(5, 1'b0, 1'b1, 32'h2000_0004, 32'h0, 32'hA5A5_5A5A);
      set_entry(6, 1'b0, 1'b1, 32'h3000_0004, 32'h0, 32'hA5A5_5A5A);
      // write protect on, ctrl reads back bit 0 only
      set_entry(7, 1'b1, 1'b0, 32'h2000_0008, 32'h0000_00FF, 32'h0);
      set_entry(8, 1'b0, 1'b1, 32'h2000_0008, 32'h0, 32'h0000_0001);
      set_entry(9, 1'b1, 1'b0, 32'h1000_0010, 32'hFFFF_0000, 32'h0);
      set_entry(10, 1'b0, 1'b1, 32'h1000_0010, 32'h0, 32'h1234_5678);
      // protect off through the alias, writes land again
      set_entry(11, 1'b1, 1'b0, 32'h3000_0008, 32'h0, 32'h0);
      set_entry(12, 1'b1, 1'b0, 32'h1000_0010, 32'hCAFE_F00D, 32'h0);
      set_entry(13, 1'b0, 1'b1, 32'h1000_0010, 32'h0, 32'hCAFE_F00D);
      // unmapped accesses and the error counter
      set_entry(14, 1'b0, 1'b1, 32'h2000_000C, 32'h0, 32'h0);
      set_entry(15, 1'b0, 1'b1, 32'h0000_0000, 32'h0, `SOC_BUS_ERR_DATA);
      set_entry(16, 1'b0, 1'b1, 32'h4000_0000, 32'h0, `SOC_BUS_ERR_DATA);
      set_entry(17, 1'b1, 1'b0, 32'hF000_0000, 32'h1111_2222, 32'h0);
      set_entry(18, 1'b0, 1'b1, 32'h2000_000C, 32'h0, 32'h0000_0003);
      set_entry(19, 1'b1, 1'b0, 32'h2000_000C, 32'h0000_0055, 32'h0);
      set_entry(20, 1'b0, 1'b1, 32'h2000_000C, 32'h0, 32'h0);
   endtask

   //-------------------------------------------------------------------
   // main sequence
   //-------------------------------------------------------------------
   initial begin
      logic [31:0] got;
      logic [31:0] addr;
      logic [31:0] data;
      logic [9:0]  idx;
      logic [9:0]  wr_idx [$];
      cpu_req   = '0;
      rst       = 1'b1;
      n_checks  = 0;
      n_errors  = 0;
      rnd_state = 32'd73216;
      load_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < N_TBL; i++) begin
         bus_access(tbl[i].we, tbl[i].addr, tbl[i].wdat, got);
         if (tbl[i].chk) begin
            check_rdat(tbl[i].addr, tbl[i].exp, got);
         end
      end

      // random words at random aliases of the window
      for (int i = 0; i < N_RAND; i++) begin
         addr = 32'h1000_0000 | (next_rand() & 32'h0FFF_FFFC);
         data = next_rand();
         idx  = addr[11:2];
         model[idx] = data;
         wr_idx.push_back(idx);
         bus_access(1'b1, addr, data, got);
      end
      // read back through another alias
      while (wr_idx.size() > 0) begin
         idx  = wr_idx.pop_front();
         data = next_rand();
         addr = {4'h1, data[27:12], idx, 2'b00};
         bus_access(1'b0, addr, 32'h0, got);
         check_rdat(addr, model[idx], got);
      end

      @(negedge clk);
      cpu_req.vld = 1'b0;
      @(negedge clk);
      if (DUT.u_props.fail_cnt != 0) begin
         $display("bound bus assertions failed %0d times", DUT.u_props.fail_cnt);
         n_errors += DUT.u_props.fail_cnt;
      end
      $display("checks: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule : tb_soc_top

// File: verilog.f
+incdir+hw
hw/soc_pkg.sv
hw/soc_fabric.sv
hw/soc_dmem.sv
hw/soc_csr.sv
hw/soc_top.sv
bench/soc_properties.sv
bench/tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the SOC bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module tb_soc_top \
   -o Vtb_soc_top

# keep running after an assertion so the testbench prints its verdict
./obj_dir/Vtb_soc_top +verilator+error+limit+1000 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
